// File: common/rom_check_consts.svh
`ifndef ROM_CHECK_CONSTS_SVH
`define ROM_CHECK_CONSTS_SVH

// Number of 32-bit words in the ROM image
`define ROM_DEPTH 32

// The top words of the ROM hold the expected digest, one word per hash lane
`define TOP_COUNT 4

// Word address width, enough to reach ROM_DEPTH-1
`define ROM_AW 5

// Additive constant applied on every absorb step
`define HASH_ADD 32'h9e3779b9

// Left rotation applied to a lane after the word is mixed in
`define HASH_ROT 5

// Lane j starts at this value plus j
`define HASH_IV 32'h6a09e667

`endif

// File: common/rom_check_pkg.sv
`include "rom_check_consts.svh"

package rom_check_pkg;

  // One word as it comes out of the ROM
  typedef logic [31:0] rom_word_t;

  // A word address into the ROM
  typedef logic [`ROM_AW-1:0] rom_addr_t;

  // Index of one digest word among the TOP_COUNT top words
  typedef logic [1:0] top_idx_t;

  // The full digest, word 0 sits in the least significant bits
  typedef logic [`TOP_COUNT*32-1:0] digest_t;

  // Checker FSM states
  // The codes are the nonzero words of a linear code with minimum weight 3, so any two states
  // are at least three bit flips apart and a single flip always lands on an illegal code
  typedef enum logic [5:0] {
    ReadingLow  = 6'b100110,
    ReadingHigh = 6'b010101,
    RomAhead    = 6'b001011,
    HashAhead   = 6'b110011,
    Checking    = 6'b101101,
    Done        = 6'b011110,
    Invalid     = 6'b111000
  } fsm_state_e;

endpackage

// File: design/rom_check_counter.sv
`include "rom_check_consts.svh"

module rom_check_counter
  import rom_check_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      data_rdy_i,
  output logic      read_req_o,
  output rom_addr_t read_addr_o,
  output rom_addr_t data_addr_o,
  output logic      last_low_o,
  output logic      done_o
);

  localparam rom_addr_t LastAddr = rom_addr_t'(`ROM_DEPTH - 1);
  localparam rom_addr_t LastLow  = rom_addr_t'(`ROM_DEPTH - `TOP_COUNT - 1);

  // addr_q is the next address to read, it parks on the last address once every word has gone
  rom_addr_t addr_q;
  logic      all_issued_q;

  // Address of the word the ROM is returning in this cycle, and whether there is one at all
  rom_addr_t data_addr_q;
  logic      data_vld_q;
  logic      done_q;

  // A read goes out on every cycle the consumer can take the answer
  assign read_req_o = data_rdy_i && !all_issued_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q       <= '0;
      all_issued_q <= 1'b0;
      data_addr_q  <= '0;
      data_vld_q   <= 1'b0;
      done_q       <= 1'b0;
    end else begin
      data_vld_q <= read_req_o;
      if (read_req_o) begin
        data_addr_q <= addr_q;
        if (addr_q == LastAddr) begin
          all_issued_q <= 1'b1;
        end else begin
          addr_q <= addr_q + 1'b1;
        end
      end
      // Sticky, rises the cycle after the final word comes back
      if (data_vld_q && data_addr_q == LastAddr) begin
        done_q <= 1'b1;
      end
    end
  end

  assign read_addr_o = addr_q;
  assign data_addr_o = data_addr_q;
  assign last_low_o  = data_vld_q && (data_addr_q == LastLow);
  assign done_o      = done_q;

  // The sweep only moves forward until it has finished
  addr_monotonic_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !done_q |=> (addr_q >= $past(addr_q))
  );

endmodule

// File: rom_check_fsm/rom_check_fsm.sv
`include "rom_check_consts.svh"

module rom_check_fsm
  import rom_check_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,

  // Address counter
  input  logic      ctr_done_i,
  input  logic      ctr_last_low_i,
  input  logic      ctr_read_req_i,
  input  rom_addr_t ctr_data_addr_i,
  output logic      ctr_data_rdy_o,

  // Word stream towards the hash engine
  input  logic      hash_rdy_i,
  output logic      hash_vld_o,
  output logic      hash_last_o,

  // Hash result strobe
  input  logic      hash_done_i,

  // Compare block
  input  logic      cmp_done_i,
  output logic      cmp_start_o,

  // Expected digest words snooped from the ROM read stream
  output logic      exp_vld_o,
  output top_idx_t  exp_idx_o,

  // Status
  output logic      done_o,
  output logic      bus_sel_o,
  output logic      alert_o
);

  // First address of the expected digest at the top of the ROM
  localparam rom_addr_t TopStart = rom_addr_t'(`ROM_DEPTH - `TOP_COUNT);

  // The state graph is a straight line apart from one race branch
  // ReadingLow streams the low words into the hash engine
  // ReadingHigh reads the top words while the hash is still running
  // RomAhead means the sweep has finished first and we wait for the hash
  // HashAhead means the hash has finished first and the sweep is still going
  // Checking runs the word by word comparison
  // Done is terminal, Invalid is terminal and raises the alert
  fsm_state_e state_d, state_q;
  logic       fsm_alert;

  always_comb begin
    state_d   = state_q;
    fsm_alert = 1'b0;

    unique case (state_q)
      ReadingLow: begin
        // Move on once the last low word has actually been handed over
        if (ctr_last_low_i && hash_vld_o && hash_rdy_i) begin
          state_d = ReadingHigh;
        end
      end

      ReadingHigh: begin
        unique case ({hash_done_i, ctr_done_i})
          2'b01:   state_d = RomAhead;
          2'b10:   state_d = HashAhead;
          2'b11:   state_d = Checking;
          default: state_d = ReadingHigh;
        endcase
      end

      RomAhead: begin
        if (hash_done_i) begin
          state_d = Checking;
        end
      end

      HashAhead: begin
        if (ctr_done_i) begin
          state_d = Checking;
        end
      end

      Checking: begin
        if (cmp_done_i) begin
          state_d = Done;
        end
      end

      Done: begin
        state_d = Done;
      end

      default: begin
        // Covers Invalid and every illegal code a glitch could leave behind
        fsm_alert = 1'b1;
        state_d   = Invalid;
      end
    endcase

    // A done strobe that arrives in the wrong state means the control flow was disturbed
    // The counter must also hold its done flag for good once we sit in Done
    if ((cmp_done_i && !(state_q inside {Checking, Done})) ||
        (ctr_done_i && state_q == ReadingLow) ||
        (hash_done_i && !(state_q inside {ReadingHigh, RomAhead})) ||
        (state_q == Done && !ctr_done_i)) begin
      state_d = Invalid;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ReadingLow;
    end else begin
      state_q <= state_d;
    end
  end

  // Data from the ROM is valid one cycle after each request
  logic data_vld_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_vld_q <= 1'b0;
    end else begin
      data_vld_q <= ctr_read_req_i;
    end
  end

  // Hash stream valid
  // Each read issued in ReadingLow produces one word for the hash next cycle, and the word leaves
  // as soon as the hash shows ready
  logic hash_vld_d, hash_vld_q;

  always_comb begin
    hash_vld_d = hash_vld_q;
    if (hash_rdy_i) begin
      hash_vld_d = 1'b0;
    end
    if (ctr_read_req_i && state_q == ReadingLow) begin
      hash_vld_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hash_vld_q <= 1'b0;
    end else begin
      hash_vld_q <= hash_vld_d;
    end
  end

  assign hash_vld_o  = hash_vld_q;
  assign hash_last_o = ctr_last_low_i;

  // In ReadingLow a read only goes out when the hash is ready and idle, so the returning word is
  // taken on the very next cycle while the ROM still presents it
  // The top words are not hashed, so they are read back to back
  assign ctr_data_rdy_o = (state_q == ReadingLow && hash_rdy_i && !hash_vld_q) ||
                          (state_q inside {ReadingHigh, HashAhead});

  // Expected digest words are the top words returning while the sweep is still running
  rom_addr_t rel_addr;

  assign rel_addr  = ctr_data_addr_i - TopStart;
  assign exp_vld_o = data_vld_q && (state_q inside {ReadingHigh, HashAhead});
  assign exp_idx_o = rel_addr[1:0];

  // Kick the compare block off when the FSM moves into Checking
  logic cmp_start_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmp_start_q <= 1'b0;
    end else begin
      cmp_start_q <= (state_q != Checking) && (state_d == Checking);
    end
  end

  assign cmp_start_o = cmp_start_q;

  // The checker owns the ROM until it reaches Done
  assign done_o    = (state_q == Done);
  assign bus_sel_o = (state_q == Done);
  assign alert_o   = fsm_alert;

  // The counter flags the last low word, this FSM must already be presenting it as valid
  last_implies_valid_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni || state_q == Invalid)
    hash_last_o |-> hash_vld_o
  );

  // Once the low part has been hashed, there is no path back into ReadingLow
  no_return_low_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (state_q != ReadingLow) |=> (state_q != ReadingLow)
  );

endmodule

// File: design/rom_check_hash.sv
`include "rom_check_consts.svh"

module rom_check_hash
  import rom_check_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      vld_i,
  input  logic      last_i,
  input  rom_word_t data_i,
  output logic      rdy_o,
  output logic      done_o,
  output digest_t   digest_o
);

  function automatic rom_word_t rotl(input rom_word_t x, input int unsigned n);
    rotl = (x << n) | (x >> (32 - n));
  endfunction

  // Low word k goes into lane k mod 4
  rom_word_t lane_q [`TOP_COUNT];
  top_idx_t  lane_idx_q;

  logic rdy_q;
  logic last_seen_q;
  logic fin_q;
  logic done_q;
  logic accept;

  assign accept = vld_i && rdy_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int j = 0; j < `TOP_COUNT; j++) begin
        lane_q[j] <= `HASH_IV + 32'(j);
      end
      lane_idx_q  <= '0;
      rdy_q       <= 1'b0;
      last_seen_q <= 1'b0;
      fin_q       <= 1'b0;
      done_q      <= 1'b0;
    end else begin
      // Ready drops for one cycle after each word and stays low for good after the last one
      rdy_q  <= !accept && !last_seen_q;
      fin_q  <= accept && last_i;
      done_q <= fin_q;

      if (accept) begin
        lane_q[lane_idx_q] <= rotl(lane_q[lane_idx_q] ^ data_i, `HASH_ROT) + `HASH_ADD;
        lane_idx_q         <= lane_idx_q + 1'b1;
        if (last_i) begin
          last_seen_q <= 1'b1;
        end
      end

      // Finalize mixes each lane with its right neighbour using the old values
      if (fin_q) begin
        for (int j = 0; j < `TOP_COUNT; j++) begin
          lane_q[j] <= lane_q[j] ^ rotl(lane_q[(j + 1) % `TOP_COUNT], 11);
        end
      end
    end
  end

  assign rdy_o  = rdy_q;
  assign done_o = done_q;

  always_comb begin
    for (int j = 0; j < `TOP_COUNT; j++) begin
      digest_o[j*32 +: 32] = lane_q[j];
    end
  end

  // Upstream must stop offering words once the last one has been absorbed
  no_word_after_last_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    last_seen_q |-> !vld_i
  );

endmodule

// File: design/rom_check_compare.sv
`include "rom_check_consts.svh"

module rom_check_compare
  import rom_check_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      exp_vld_i,
  input  top_idx_t  exp_idx_i,
  input  rom_word_t exp_data_i,
  input  logic      digest_vld_i,
  input  digest_t   digest_i,
  input  logic      start_i,
  output logic      done_o,
  output logic      good_o
);

  localparam top_idx_t LastIdx = top_idx_t'(`TOP_COUNT - 1);

  // Expected words from the top of the ROM and the words the hash computed
  rom_word_t exp_q [`TOP_COUNT];
  rom_word_t dig_q [`TOP_COUNT];

  always_ff @(posedge clk_i) begin
    if (exp_vld_i) begin
      exp_q[exp_idx_i] <= exp_data_i;
    end
    if (digest_vld_i) begin
      for (int j = 0; j < `TOP_COUNT; j++) begin
        dig_q[j] <= digest_i[j*32 +: 32];
      end
    end
  end

  // One word is compared per cycle, so done lands TOP_COUNT+1 cycles after start
  logic     running_q;
  top_idx_t idx_q;
  logic     match_q;
  logic     match_d;
  logic     done_q;
  logic     good_q;

  assign match_d = match_q && (exp_q[idx_q] == dig_q[idx_q]);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q <= 1'b0;
      idx_q     <= '0;
      match_q   <= 1'b0;
      done_q    <= 1'b0;
      good_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        running_q <= 1'b1;
        idx_q     <= '0;
        match_q   <= 1'b1;
      end else if (running_q) begin
        match_q <= match_d;
        idx_q   <= idx_q + 1'b1;
        if (idx_q == LastIdx) begin
          running_q <= 1'b0;
          done_q    <= 1'b1;
          good_q    <= match_d;
        end
      end
    end
  end

  assign done_o = done_q;
  assign good_o = good_q;

endmodule

// File: design/rom_check_top.sv
module rom_check_top
  import rom_check_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  rom_word_t rom_data_i,
  output logic      rom_req_o,
  output rom_addr_t rom_addr_o,
  output digest_t   digest_o,
  output logic      digest_vld_o,
  output logic      done_o,
  output logic      good_o,
  output logic      bus_sel_o,
  output logic      alert_o
);

  // Counter to FSM
  logic      ctr_done, ctr_last_low, ctr_read_req, ctr_data_rdy;
  rom_addr_t ctr_read_addr, ctr_data_addr;

  // FSM to hash stream and hash result
  logic      hash_vld, hash_last, hash_rdy, hash_done;
  digest_t   hash_digest;

  // FSM to compare
  logic      cmp_start, cmp_done, cmp_good;
  logic      exp_vld;
  top_idx_t  exp_idx;

  rom_check_counter i_counter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .data_rdy_i  (ctr_data_rdy),
    .read_req_o  (ctr_read_req),
    .read_addr_o (ctr_read_addr),
    .data_addr_o (ctr_data_addr),
    .last_low_o  (ctr_last_low),
    .done_o      (ctr_done)
  );

  rom_check_fsm i_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .ctr_done_i      (ctr_done),
    .ctr_last_low_i  (ctr_last_low),
    .ctr_read_req_i  (ctr_read_req),
    .ctr_data_addr_i (ctr_data_addr),
    .ctr_data_rdy_o  (ctr_data_rdy),
    .hash_rdy_i      (hash_rdy),
    .hash_vld_o      (hash_vld),
    .hash_last_o     (hash_last),
    .hash_done_i     (hash_done),
    .cmp_done_i      (cmp_done),
    .cmp_start_o     (cmp_start),
    .exp_vld_o       (exp_vld),
    .exp_idx_o       (exp_idx),
    .done_o          (done_o),
    .bus_sel_o       (bus_sel_o),
    .alert_o         (alert_o)
  );

  // ROM data feeds both the hash and the expected digest store
  rom_check_hash i_hash (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .vld_i    (hash_vld),
    .last_i   (hash_last),
    .data_i   (rom_data_i),
    .rdy_o    (hash_rdy),
    .done_o   (hash_done),
    .digest_o (hash_digest)
  );

  rom_check_compare i_compare (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .exp_vld_i    (exp_vld),
    .exp_idx_i    (exp_idx),
    .exp_data_i   (rom_data_i),
    .digest_vld_i (hash_done),
    .digest_i     (hash_digest),
    .start_i      (cmp_start),
    .done_o       (cmp_done),
    .good_o       (cmp_good)
  );

  assign rom_req_o    = ctr_read_req;
  assign rom_addr_o   = ctr_read_addr;
  assign digest_o     = hash_digest;
  assign digest_vld_o = hash_done;
  assign good_o       = cmp_good;

endmodule

// File: verif/rom_check_tb.sv
`include "rom_check_consts.svh"

module rom_check_tb
  import rom_check_pkg::*;
();

  localparam int Depth    = `ROM_DEPTH;
  localparam int LowCount = `ROM_DEPTH - `TOP_COUNT;
  localparam int NumRuns  = 6;
  localparam int Timeout  = 2000;

  logic      clk_i;
  logic      rst_ni;
  rom_word_t rom_data_i;
  logic      rom_req_o;
  rom_addr_t rom_addr_o;
  digest_t   digest_o;
  logic      digest_vld_o;
  logic      done_o;
  logic      good_o;
  logic      bus_sel_o;
  logic      alert_o;

  // ROM contents for the current run and the digest the hash should produce from them
  rom_word_t   rom_image [`ROM_DEPTH];
  digest_t     model_digest;
  logic [31:0] rng_state;

  int unsigned error_count;
  int unsigned check_count;

  // Bus monitor state is cleared while reset is held
  int unsigned next_addr;
  int unsigned digest_pulses;
  logic        done_seen;

  rom_check_top i_dut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rom_data_i   (rom_data_i),
    .rom_req_o    (rom_req_o),
    .rom_addr_o   (rom_addr_o),
    .digest_o     (digest_o),
    .digest_vld_o (digest_vld_o),
    .done_o       (done_o),
    .good_o       (good_o),
    .bus_sel_o    (bus_sel_o),
    .alert_o      (alert_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // 32-bit xorshift step
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic rom_word_t rotate_left(input rom_word_t x, input int unsigned n);
    return (x << n) | (x >> (32 - n));
  endfunction

  // Reference hash over the low words of rom_image
  // Word k mixes into lane k mod 4 and one finalize pass then folds in the right neighbour
  function automatic digest_t model_hash();
    rom_word_t lane  [`TOP_COUNT];
    rom_word_t mixed [`TOP_COUNT];
    digest_t   result;
    for (int j = 0; j < `TOP_COUNT; j++) begin
      lane[j] = `HASH_IV + 32'(j);
    end
    for (int k = 0; k < LowCount; k++) begin
      lane[k % `TOP_COUNT] = rotate_left(lane[k % `TOP_COUNT] ^ rom_image[k], `HASH_ROT)
                             + `HASH_ADD;
    end
    // All neighbours are taken from the lanes before finalize
    for (int j = 0; j < `TOP_COUNT; j++) begin
      mixed[j] = lane[j] ^ rotate_left(lane[(j + 1) % `TOP_COUNT], 11);
    end
    for (int j = 0; j < `TOP_COUNT; j++) begin
      result[j*32 +: 32] = mixed[j];
    end
    return result;
  endfunction

  // Mode 0 leaves the image intact
  // Mode 1 corrupts one low word and mode 2 one expected word
  task automatic build_image(input int unsigned mode);
    int unsigned pos;
    rom_word_t   flip;
    for (int a = 0; a < Depth; a++) begin
      rom_image[a] = next_random();
    end
    model_digest = model_hash();
    for (int j = 0; j < `TOP_COUNT; j++) begin
      rom_image[LowCount + j] = model_digest[j*32 +: 32];
    end
    // Forcing bit 0 keeps the flip mask nonzero
    flip = next_random() | 32'h1;
    if (mode == 1) begin
      pos = next_random() % LowCount;
      rom_image[pos] = rom_image[pos] ^ flip;
      // The hash now sees the corrupted word while the top words still hold the old digest
      model_digest = model_hash();
    end else if (mode == 2) begin
      pos = LowCount + (next_random() % `TOP_COUNT);
      rom_image[pos] = rom_image[pos] ^ flip;
    end
  endtask

  task automatic compare_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
    check_count++;
    assert (actual === expected) else begin
      error_count++;
      $display("** Error: %s = %0h, expected %0h", name, actual, expected);
    end
  endtask

  // Holds reset for two cycles and checks that every output is idle meanwhile
  task automatic apply_reset();
    @(posedge clk_i);
    rst_ni <= 1'b0;
    @(posedge clk_i);
    @(negedge clk_i);
    compare_value("rom_req_o", 128'(rom_req_o), 128'(0));
    compare_value("done_o", 128'(done_o), 128'(0));
    compare_value("good_o", 128'(good_o), 128'(0));
    compare_value("alert_o", 128'(alert_o), 128'(0));
    compare_value("digest_vld_o", 128'(digest_vld_o), 128'(0));
    compare_value("bus_sel_o", 128'(bus_sel_o), 128'(0));
    @(posedge clk_i);
    rst_ni <= 1'b1;
  endtask

  task automatic wait_done(output logic reached);
    int unsigned cycles;
    cycles  = 0;
    reached = 1'b0;
    while (!reached && cycles < Timeout) begin
      @(negedge clk_i);
      if (done_o) begin
        reached = 1'b1;
      end
      cycles++;
    end
    assert (reached) else begin
      error_count++;
      $display("Timeout: done_o did not rise within %0d cycles", Timeout);
    end
  endtask

  // ROM answers each request on the next cycle
  always @(posedge clk_i) begin
    if (rom_req_o) begin
      rom_data_i <= rom_image[rom_addr_o];
    end
  end

  // Bus monitor sampling in the middle of the cycle
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      next_addr     = 0;
      digest_pulses = 0;
      done_seen     = 1'b0;
    end else begin
      compare_value("alert_o", 128'(alert_o), 128'(0));
      if (done_seen) begin
        compare_value("done_o", 128'(done_o), 128'(1));
        compare_value("rom_req_o", 128'(rom_req_o), 128'(0));
        compare_value("bus_sel_o", 128'(bus_sel_o), 128'(1));
      end else if (!done_o) begin
        // The checker keeps the ROM port for the whole sweep and compare
        compare_value("bus_sel_o", 128'(bus_sel_o), 128'(0));
      end
      if (rom_req_o) begin
        compare_value("rom_addr_o", 128'(rom_addr_o), 128'(next_addr));
        next_addr++;
      end
      if (digest_vld_o) begin
        compare_value("digest_o", digest_o, model_digest);
        digest_pulses++;
      end
      if (done_o) begin
        done_seen = 1'b1;
      end
    end
  end

  initial begin
    int unsigned mode;
    logic        reached;
    rst_ni      = 1'b0;
    rom_data_i  = '0;
    rng_state   = 32'h84d7;
    error_count = 0;
    check_count = 0;

    for (int run = 0; run < NumRuns; run++) begin
      mode = run % 3;
      build_image(mode);
      apply_reset();
      wait_done(reached);
      if (reached) begin
        compare_value("good_o", 128'(good_o), 128'(mode == 0));
        compare_value("bus_sel_o", 128'(bus_sel_o), 128'(1));
        // Let the DUT idle for a while so that late requests or a dropped done show up
        repeat (10) @(negedge clk_i);
        compare_value("done_o", 128'(done_o), 128'(1));
        compare_value("good_o", 128'(good_o), 128'(mode == 0));
      end
      assert (next_addr == Depth) else begin
        error_count++;
        $display("Run %0d issued %0d ROM requests instead of %0d", run, next_addr, Depth);
      end
      assert (digest_pulses == 1) else begin
        error_count++;
        $display("Run %0d saw %0d digest_vld_o pulses instead of one", run, digest_pulses);
      end
    end

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: rom_check.f
+incdir+common
common/rom_check_pkg.sv
design/rom_check_counter.sv
rom_check_fsm/rom_check_fsm.sv
design/rom_check_hash.sv
design/rom_check_compare.sv
design/rom_check_top.sv
verif/rom_check_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the ROM checker testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module rom_check_tb \
  -f rom_check.f \
  -o rom_check_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/rom_check_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "ALL CHECKS PASSED" sim.log; then
  exit 0
else
  echo "Pass message not found in sim.log"
  exit 1
fi
